/* logic/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int WORD_W = 16; // Instruction word
    localparam int STATE_W = 6;
    localparam int FLAG_W = 4;
    localparam int SEL_W = 4; // ALU function, ALU input and write data selects
    localparam int ADDR_SEL_W = 2;
    localparam int DEST_W = 3; // Source or destination field

    localparam logic [STATE_W-1:0] ST_START = 6'b000000;
    localparam logic [STATE_W-1:0] ST_FETCH = 6'b000001;
    localparam logic [STATE_W-1:0] ST_ATYPE = 6'b000010;
    localparam logic [STATE_W-1:0] ST_ITYPE = 6'b000011;
    localparam logic [STATE_W-1:0] ST_JTYPE = 6'b000100;
    localparam logic [STATE_W-1:0] ST_SITYPE = 6'b000101;
    localparam logic [STATE_W-1:0] ST_JFG = 6'b000110; // Taken JFS/JFC
    localparam logic [STATE_W-1:0] ST_PUSH1 = 6'b001000;
    localparam logic [STATE_W-1:0] ST_PUSH2 = 6'b001001;
    localparam logic [STATE_W-1:0] ST_POP1 = 6'b001010;
    localparam logic [STATE_W-1:0] ST_POP2 = 6'b001011;
    localparam logic [STATE_W-1:0] ST_RIMMED = 6'b010100; // Source read states
    localparam logic [STATE_W-1:0] ST_RADDRESS = 6'b010101;
    localparam logic [STATE_W-1:0] ST_HALT = 6'b111111; // CPU stopped

    localparam logic [DEST_W-1:0] DEST_0 = 3'b000; // SP, I-type only
    localparam logic [DEST_W-1:0] DEST_A = 3'b001;
    localparam logic [DEST_W-1:0] DEST_B = 3'b010;
    localparam logic [DEST_W-1:0] DEST_C = 3'b011;
    localparam logic [DEST_W-1:0] DEST_ABS = 3'b101; // Not supported
    localparam logic [DEST_W-1:0] DEST_ADR = 3'b110; // Memory at (A)
    localparam logic [DEST_W-1:0] DEST_ABSI = 3'b111; // Not supported

    localparam logic [DEST_W-1:0] SRC_IMM = 3'b100; // Source modes with a memory read
    localparam logic [DEST_W-1:0] SRC_ADR = 3'b110;

    localparam logic [3:0] OP_ATYPE = 4'b0000; // Top opcode bits
    localparam logic [1:0] OP_ITYPE = 2'b01;
    localparam logic [3:0] OP_SITYPE = 4'b0001;
    localparam logic [3:0] OP_FTYPE = 4'b0010;
    localparam logic [3:0] OP_SPTYPE = 4'b0011;
    localparam logic [1:0] SP_PUSH = 2'b00;
    localparam logic [1:0] SP_POP = 2'b01;

    localparam logic [SEL_W-1:0] ALU1_FROM_A = 4'd1; // 0 gives zero
    localparam logic [SEL_W-1:0] ALU1_FROM_B = 4'd2;
    localparam logic [SEL_W-1:0] ALU1_FROM_C = 4'd3;
    localparam logic [SEL_W-1:0] ALU1_FROM_PC = 4'd4;
    localparam logic [SEL_W-1:0] ALU1_FROM_SP = 4'd5;
    localparam logic [SEL_W-1:0] ALU1_FROM_MEM = 4'd6;

    localparam logic [SEL_W-1:0] ALU2_FROM_0 = 4'd0;
    localparam logic [SEL_W-1:0] ALU2_FROM_1 = 4'd4;
    localparam logic [SEL_W-1:0] ALU2_FROM_OP = 4'd5; // Immediate from instruction
    localparam logic [SEL_W-1:0] ALU2_FROM_ADDR = 4'd6; // Jump address

    localparam logic [ADDR_SEL_W-1:0] READ_FROM_PC = 2'd0;
    localparam logic [ADDR_SEL_W-1:0] READ_FROM_A = 2'd1;
    localparam logic [ADDR_SEL_W-1:0] READ_FROM_SP = 2'd2;
    localparam logic [ADDR_SEL_W-1:0] READ_FROM_ALU = 2'd3;

    localparam logic [SEL_W-1:0] WRITE_FROM_ALU = 4'd1;

    localparam logic [SEL_W-1:0] ALU_ADD = 4'd0;
    localparam logic [SEL_W-1:0] ALU_SUB = 4'd2;
    localparam logic [SEL_W-1:0] ALU_MUL = 4'd4;
    localparam logic [SEL_W-1:0] ALU_JUMP = 4'd6;

    typedef union packed {
        struct packed {
            logic [3:0] op;
            logic [DEST_W-1:0] src; // Bits 11..9 in every type
            logic [SEL_W-1:0] func;
            logic [1:0] srcB;
            logic [DEST_W-1:0] dest;
        } aType;
        struct packed {
            logic [1:0] op;
            logic [1:0] func;
            logic [DEST_W-1:0] srcDest; // Source and destination
            logic wide;
            logic [7:0] imm;
        } iType;
        struct packed {
            logic [3:0] op;
            logic [DEST_W-1:0] src;
            logic [1:0] func;
            logic [DEST_W-1:0] dest;
            logic [3:0] imm;
        } siType;
        struct packed {
            logic [3:0] op;
            logic flagOp; // FLS/FLC when set, else JFS/JFC
            logic value;
            logic [1:0] flagSel;
            logic [7:0] offset;
        } fType;
        struct packed {
            logic [3:0] op;
            logic [DEST_W-1:0] src;
            logic [1:0] spOp;
            logic [6:0] rsvd;
        } spType;
    } opcodeU;

endpackage

`default_nettype wire

/* logic/decodeBus.sv */
`timescale 1ns/1ps
`default_nettype none

interface decodeBus;

    cpuPkg::opcodeU instr; // Current instruction word
    logic [cpuPkg::STATE_W-1:0] mainState; // State after fetch and source read
    logic isFlagOp; // FLS/FLC
    logic [cpuPkg::DEST_W-1:0] srcMode; // Source mode, zero when nothing is read
    logic [cpuPkg::DEST_W-1:0] destField;

    modport producer (
        output instr,
        output mainState,
        output isFlagOp,
        output srcMode,
        output destField
    );

    modport consumer (
        input instr,
        input mainState,
        input isFlagOp,
        input srcMode,
        input destField
    );

endinterface

`default_nettype wire

/* logic/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    decodeBus.producer bus,
    input wire cpuPkg::opcodeU opcode,
    input wire [cpuPkg::FLAG_W-1:0] flags
);

    logic condTrue;
    logic writesDest;
    logic [cpuPkg::DEST_W-1:0] src;

    assign src = opcode.aType.src; // Same bits in all types
    assign condTrue = flags[opcode.fType.flagSel] == opcode.fType.value;
    assign bus.instr = opcode;

    always_comb begin
        bus.mainState = cpuPkg::ST_HALT;
        bus.isFlagOp = 1'b0;
        bus.srcMode = src;
        bus.destField = src;
        writesDest = 1'b0;
        if (opcode.aType.op == cpuPkg::OP_ATYPE) begin
            bus.mainState = cpuPkg::ST_ATYPE;
            bus.destField = opcode.aType.dest;
            writesDest = 1'b1;
        end else if (opcode.iType.op == cpuPkg::OP_ITYPE) begin
            bus.mainState = cpuPkg::ST_ITYPE;
            writesDest = 1'b1;
            if (opcode.iType.wide && opcode.iType.func == 2'b11) begin
                bus.srcMode = '0; // Load form, field is only a destination
            end
        end else if (opcode.aType.op[3]) begin
            bus.mainState = cpuPkg::ST_JTYPE;
            bus.srcMode = '0;
        end else if (opcode.aType.op == cpuPkg::OP_SITYPE) begin
            bus.mainState = cpuPkg::ST_SITYPE;
            bus.destField = opcode.siType.dest;
            writesDest = 1'b1;
        end else if (opcode.aType.op == cpuPkg::OP_FTYPE) begin
            bus.srcMode = '0;
            if (opcode.fType.flagOp) begin
                bus.isFlagOp = 1'b1; // Done during the next fetch
                bus.mainState = cpuPkg::ST_FETCH;
            end else begin
                bus.mainState = condTrue ? cpuPkg::ST_JFG : cpuPkg::ST_FETCH;
            end
        end else if (opcode.aType.op == cpuPkg::OP_SPTYPE) begin
            case (opcode.spType.spOp)
                cpuPkg::SP_PUSH: bus.mainState = cpuPkg::ST_PUSH1;
                cpuPkg::SP_POP: begin
                    bus.mainState = cpuPkg::ST_POP1;
                    bus.srcMode = '0;
                    writesDest = 1'b1;
                end
                default: bus.mainState = cpuPkg::ST_HALT; // SVPC and RET
            endcase
        end

        // Absolute and stack-indexed modes stop the CPU
        if (bus.srcMode[2] && bus.srcMode[0]) begin
            bus.mainState = cpuPkg::ST_HALT;
        end
        if (writesDest && (bus.destField == cpuPkg::DEST_ABS
                || bus.destField == cpuPkg::DEST_ABSI)) begin
            bus.mainState = cpuPkg::ST_HALT;
        end
        if (bus.mainState == cpuPkg::ST_HALT) begin
            bus.srcMode = '0; // No read detour on the way to halt
        end
    end

endmodule

`default_nettype wire

/* logic/stateSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module stateSequencer (
    input wire clk,
    input wire rst,
    input wire stall,
    decodeBus.consumer bus,
    output logic [cpuPkg::STATE_W-1:0] state
);

    logic [cpuPkg::STATE_W-1:0] stateNext;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cpuPkg::ST_START;
        end else if (!stall) begin
            state <= stateNext; // Stall holds the state
        end
    end

    always_comb begin
        case (state)
            cpuPkg::ST_START: stateNext = cpuPkg::ST_FETCH;
            cpuPkg::ST_FETCH: begin
                if (bus.srcMode == cpuPkg::SRC_IMM) begin
                    stateNext = cpuPkg::ST_RIMMED; // Operand follows the opcode
                end else if (bus.srcMode == cpuPkg::SRC_ADR) begin
                    stateNext = cpuPkg::ST_RADDRESS; // Operand at (A)
                end else begin
                    stateNext = bus.mainState;
                end
            end
            cpuPkg::ST_RIMMED, cpuPkg::ST_RADDRESS: stateNext = bus.mainState;
            cpuPkg::ST_ATYPE, cpuPkg::ST_ITYPE, cpuPkg::ST_SITYPE, cpuPkg::ST_JTYPE,
            cpuPkg::ST_JFG, cpuPkg::ST_PUSH2, cpuPkg::ST_POP2: begin
                stateNext = cpuPkg::ST_FETCH;
            end
            cpuPkg::ST_PUSH1: stateNext = cpuPkg::ST_PUSH2;
            cpuPkg::ST_POP1: stateNext = cpuPkg::ST_POP2;
            default: stateNext = cpuPkg::ST_HALT; // Halt and unknown codes
        endcase
    end

endmodule

`default_nettype wire

/* logic/destDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module destDecode (
    input wire writeBack,
    input wire [cpuPkg::DEST_W-1:0] dest,
    input wire allowSp,
    output logic enA,
    output logic enB,
    output logic enC,
    output logic enSP,
    output logic memWrite,
    output logic addrFromA
);

    always_comb begin
        enA = 1'b0;
        enB = 1'b0;
        enC = 1'b0;
        enSP = 1'b0;
        memWrite = 1'b0;
        addrFromA = 1'b0;
        if (writeBack) begin
            case (dest)
                cpuPkg::DEST_0: enSP = allowSp; // Other types discard the result
                cpuPkg::DEST_A: enA = 1'b1;
                cpuPkg::DEST_B: enB = 1'b1;
                cpuPkg::DEST_C: enC = 1'b1;
                cpuPkg::DEST_ADR: begin
                    memWrite = 1'b1; // Result to (A)
                    addrFromA = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/controlGen.sv */
`timescale 1ns/1ps
`default_nettype none

module controlGen (
    input wire [cpuPkg::STATE_W-1:0] state,
    decodeBus.consumer bus,
    input wire [cpuPkg::FLAG_W-1:0] flags,
    output logic [cpuPkg::ADDR_SEL_W-1:0] memAddr,
    output logic enPC,
    output logic saveOpcode,
    output logic saveMem1,
    output logic [cpuPkg::SEL_W-1:0] aluFunc,
    output logic [cpuPkg::SEL_W-1:0] aluA,
    output logic [cpuPkg::SEL_W-1:0] aluB,
    output logic enA,
    output logic enB,
    output logic enC,
    output logic we,
    output logic re,
    output logic [cpuPkg::SEL_W-1:0] writeDataSource,
    output logic enF,
    output logic sourceF,
    output logic [cpuPkg::FLAG_W-1:0] inF,
    output logic enSP,
    output logic readStack,
    output logic isMul
);

    logic [cpuPkg::ADDR_SEL_W-1:0] baseAddr;
    logic baseWe;
    logic baseEnA;
    logic baseEnSP;
    logic writeBack;
    logic allowSp;
    logic destEnA;
    logic destEnSP;
    logic memWrite;
    logic addrFromA;
    logic [cpuPkg::DEST_W-1:0] src;
    logic [cpuPkg::SEL_W-1:0] srcSel;
    logic [cpuPkg::FLAG_W-1:0] flagBit;

    assign src = bus.instr.aType.src;
    assign srcSel = src[2] ? cpuPkg::ALU1_FROM_MEM : {{(cpuPkg::SEL_W-2){1'b0}}, src[1:0]};
    assign flagBit = {{(cpuPkg::FLAG_W-1){1'b0}}, 1'b1} << bus.instr.fType.flagSel;

    destDecode destDec (
        .writeBack(writeBack),
        .dest(bus.destField),
        .allowSp(allowSp),
        .enA(destEnA),
        .enB(enB),
        .enC(enC),
        .enSP(destEnSP),
        .memWrite(memWrite),
        .addrFromA(addrFromA)
    );

    // Merge destination decode with per-state controls
    assign enA = baseEnA | destEnA;
    assign enSP = baseEnSP | destEnSP;
    assign we = baseWe | memWrite;
    assign memAddr = addrFromA ? cpuPkg::READ_FROM_A : baseAddr;
    assign writeDataSource = we ? cpuPkg::WRITE_FROM_ALU : '0;

    always_comb begin
        baseAddr = cpuPkg::READ_FROM_PC;
        enPC = 1'b0;
        saveOpcode = 1'b0;
        saveMem1 = 1'b0;
        aluFunc = cpuPkg::ALU_ADD;
        aluA = '0;
        aluB = cpuPkg::ALU2_FROM_0;
        baseEnA = 1'b0;
        baseWe = 1'b0;
        re = 1'b0;
        enF = 1'b0;
        sourceF = 1'b0;
        inF = '0;
        baseEnSP = 1'b0;
        readStack = 1'b0;
        isMul = 1'b0;
        writeBack = 1'b0;
        allowSp = 1'b0;
        case (state)
            cpuPkg::ST_FETCH: begin
                re = 1'b1; // Opcode from (PC)
                saveOpcode = 1'b1;
                aluA = cpuPkg::ALU1_FROM_PC; // PC + 1
                aluB = cpuPkg::ALU2_FROM_1;
                enPC = 1'b1;
                if (bus.isFlagOp) begin
                    enF = 1'b1;
                    sourceF = 1'b1; // Flags from inF
                    inF = bus.instr.fType.value ? (flags | flagBit) : (flags & ~flagBit);
                end
            end
            cpuPkg::ST_ATYPE: begin
                aluA = srcSel;
                aluB = {2'b00, bus.instr.aType.srcB};
                aluFunc = bus.instr.aType.func;
                enF = 1'b1;
                writeBack = 1'b1;
                if (bus.instr.aType.func == cpuPkg::ALU_MUL) begin
                    isMul = 1'b1; // High half goes to A
                    baseEnA = 1'b1;
                end
            end
            cpuPkg::ST_ITYPE: begin
                aluA = (src == cpuPkg::DEST_0) ? cpuPkg::ALU1_FROM_SP : srcSel;
                aluB = cpuPkg::ALU2_FROM_OP;
                aluFunc = {bus.instr.iType.wide, bus.instr.iType.wide, bus.instr.iType.func};
                enF = 1'b1;
                writeBack = 1'b1;
                allowSp = 1'b1;
            end
            cpuPkg::ST_SITYPE: begin
                aluA = srcSel;
                aluB = cpuPkg::ALU2_FROM_OP;
                aluFunc = {2'b10, bus.instr.siType.func}; // Shift group
                enF = 1'b1;
                writeBack = 1'b1;
            end
            cpuPkg::ST_JTYPE: begin
                aluA = cpuPkg::ALU1_FROM_PC;
                aluB = cpuPkg::ALU2_FROM_ADDR;
                aluFunc = cpuPkg::ALU_JUMP;
                enPC = 1'b1;
            end
            cpuPkg::ST_JFG: begin
                aluA = cpuPkg::ALU1_FROM_PC; // PC + offset
                aluB = cpuPkg::ALU2_FROM_OP;
                enPC = 1'b1;
            end
            cpuPkg::ST_PUSH1: begin
                aluA = srcSel; // Source + 0
                baseWe = 1'b1;
                readStack = 1'b1;
                baseAddr = cpuPkg::READ_FROM_SP;
            end
            cpuPkg::ST_PUSH2: begin
                aluA = cpuPkg::ALU1_FROM_SP; // SP - 1
                aluB = cpuPkg::ALU2_FROM_1;
                aluFunc = cpuPkg::ALU_SUB;
                baseEnSP = 1'b1;
            end
            cpuPkg::ST_POP1: begin
                aluA = cpuPkg::ALU1_FROM_SP; // SP + 1
                aluB = cpuPkg::ALU2_FROM_1;
                baseEnSP = 1'b1;
                baseAddr = cpuPkg::READ_FROM_ALU;
                readStack = 1'b1;
                saveMem1 = 1'b1;
                re = 1'b1;
            end
            cpuPkg::ST_POP2: begin
                aluA = cpuPkg::ALU1_FROM_MEM; // Popped value + 0
                writeBack = 1'b1;
            end
            cpuPkg::ST_RIMMED: begin
                saveMem1 = 1'b1; // Operand from (PC)
                re = 1'b1;
                aluA = cpuPkg::ALU1_FROM_PC;
                aluB = cpuPkg::ALU2_FROM_1;
                enPC = 1'b1;
            end
            cpuPkg::ST_RADDRESS: begin
                baseAddr = cpuPkg::READ_FROM_A;
                saveMem1 = 1'b1;
                re = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/cpuController.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuController (
    input wire clk,
    input wire rst,
    input wire [cpuPkg::WORD_W-1:0] opcode, // Instruction register
    input wire [cpuPkg::FLAG_W-1:0] flags,
    input wire stall,
    output logic [cpuPkg::ADDR_SEL_W-1:0] memAddr,
    output logic enPC,
    output logic saveOpcode,
    output logic saveMem1,
    output logic [cpuPkg::SEL_W-1:0] aluFunc,
    output logic [cpuPkg::SEL_W-1:0] aluA,
    output logic [cpuPkg::SEL_W-1:0] aluB,
    output logic enA,
    output logic enB,
    output logic enC,
    output logic we,
    output logic re,
    output logic [cpuPkg::SEL_W-1:0] writeDataSource,
    output logic enF,
    output logic sourceF,
    output logic [cpuPkg::FLAG_W-1:0] inF,
    output logic enSP,
    output logic readStack,
    output logic isMul,
    output logic [cpuPkg::STATE_W-1:0] state // Debug view
);

    cpuPkg::opcodeU opcodeWord;

    assign opcodeWord = opcode;

    decodeBus decBus ();

    instrDecoder decoder (
        .bus(decBus.producer),
        .opcode(opcodeWord),
        .flags(flags)
    );

    stateSequencer sequencer (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .bus(decBus.consumer),
        .state(state)
    );

    controlGen ctrl (
        .state(state),
        .bus(decBus.consumer),
        .flags(flags),
        .memAddr(memAddr),
        .enPC(enPC),
        .saveOpcode(saveOpcode),
        .saveMem1(saveMem1),
        .aluFunc(aluFunc),
        .aluA(aluA),
        .aluB(aluB),
        .enA(enA),
        .enB(enB),
        .enC(enC),
        .we(we),
        .re(re),
        .writeDataSource(writeDataSource),
        .enF(enF),
        .sourceF(sourceF),
        .inF(inF),
        .enSP(enSP),
        .readStack(readStack),
        .isMul(isMul)
    );

endmodule

`default_nettype wire

/* tb/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0; // Released just after the second edge
    end

endmodule

`default_nettype wire

/* tb/cpuControllerTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuControllerTb;

    localparam int FIELDS = 22; // Words per vector line
    localparam int MAX_VECTORS = 64;
    localparam int MEM_WORDS = FIELDS * MAX_VECTORS;
    localparam int TIMEOUT_MARGIN = 20;
    localparam string VEC_FILE = "tb/controllerVectors.txt";

    logic clk;
    logic rst;
    cpuPkg::opcodeU opcode;
    logic [cpuPkg::FLAG_W-1:0] flags;
    logic stall;
    logic [cpuPkg::ADDR_SEL_W-1:0] memAddr;
    logic enPC;
    logic saveOpcode;
    logic saveMem1;
    logic [cpuPkg::SEL_W-1:0] aluFunc;
    logic [cpuPkg::SEL_W-1:0] aluA;
    logic [cpuPkg::SEL_W-1:0] aluB;
    logic enA;
    logic enB;
    logic enC;
    logic we;
    logic re;
    logic [cpuPkg::SEL_W-1:0] writeDataSource;
    logic enF;
    logic sourceF;
    logic [cpuPkg::FLAG_W-1:0] inF;
    logic enSP;
    logic readStack;
    logic isMul;
    logic [cpuPkg::STATE_W-1:0] state;

    logic [15:0] vecMem [0:MEM_WORDS-1];
    int vecCount;
    int vecIdx;
    int cycleCount = 0;

    tbClock clockGen (
        .clk(clk),
        .rst(rst)
    );

    cpuController DUT (.*);

    task automatic stopOnFailure();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkState(input string name, input logic [cpuPkg::STATE_W-1:0] got,
            input logic [cpuPkg::STATE_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h at vector %0d", name, got, exp, vecIdx);
            stopOnFailure();
        end
    endtask

    task automatic checkSelect(input string name, input logic [cpuPkg::SEL_W-1:0] got,
            input logic [cpuPkg::SEL_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h at vector %0d", name, got, exp, vecIdx);
            stopOnFailure();
        end
    endtask

    task automatic checkAddrSel(input string name, input logic [cpuPkg::ADDR_SEL_W-1:0] got,
            input logic [cpuPkg::ADDR_SEL_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h at vector %0d", name, got, exp, vecIdx);
            stopOnFailure();
        end
    endtask

    task automatic checkFlags(input string name, input logic [cpuPkg::FLAG_W-1:0] got,
            input logic [cpuPkg::FLAG_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h at vector %0d", name, got, exp, vecIdx);
            stopOnFailure();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h at vector %0d", name, got, exp, vecIdx);
            stopOnFailure();
        end
    endtask

    task automatic loadVectors();
        for (int i = 0; i < MEM_WORDS; i++) begin
            vecMem[i] = 16'h8000 | 16'(i); // Top bit marks an unloaded word
        end
        $readmemh(VEC_FILE, vecMem);
        vecCount = 0;
        while (vecCount < MAX_VECTORS && !vecMem[vecCount * FIELDS + 2][15]) begin
            vecCount++; // Stall word is 0 or 1 in a real line
        end
    endtask

    task automatic applyVector(input int base);
        opcode = vecMem[base];
        flags = vecMem[base + 1][cpuPkg::FLAG_W-1:0];
        stall = vecMem[base + 2][0];
    endtask

    task automatic checkVector(input int base);
        checkState("state", state, vecMem[base + 3][cpuPkg::STATE_W-1:0]);
        checkSelect("aluFunc", aluFunc, vecMem[base + 4][cpuPkg::SEL_W-1:0]);
        checkSelect("aluA", aluA, vecMem[base + 5][cpuPkg::SEL_W-1:0]);
        checkSelect("aluB", aluB, vecMem[base + 6][cpuPkg::SEL_W-1:0]);
        checkAddrSel("memAddr", memAddr, vecMem[base + 7][cpuPkg::ADDR_SEL_W-1:0]);
        checkBit("enA", enA, vecMem[base + 8][0]);
        checkBit("enB", enB, vecMem[base + 9][0]);
        checkBit("enC", enC, vecMem[base + 10][0]);
        checkBit("enSP", enSP, vecMem[base + 11][0]);
        checkBit("we", we, vecMem[base + 12][0]);
        checkBit("re", re, vecMem[base + 13][0]);
        checkBit("enPC", enPC, vecMem[base + 14][0]);
        checkBit("saveOpcode", saveOpcode, vecMem[base + 15][0]);
        checkBit("saveMem1", saveMem1, vecMem[base + 16][0]);
        checkBit("isMul", isMul, vecMem[base + 17][0]);
        checkBit("enF", enF, vecMem[base + 18][0]);
        checkBit("sourceF", sourceF, vecMem[base + 19][0]);
        checkBit("readStack", readStack, vecMem[base + 20][0]);
        checkFlags("inF", inF, vecMem[base + 21][cpuPkg::FLAG_W-1:0]);
        if (vecMem[base + 12][0]) begin
            checkSelect("writeDataSource", writeDataSource,
                cpuPkg::WRITE_FROM_ALU); // Only ALU data is written
        end
    endtask

    // Run limit from the vector count
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= vecCount + TIMEOUT_MARGIN) begin
            $display("Timeout after %0d cycles with vectors still pending", cycleCount);
            stopOnFailure();
        end
    end

    initial begin
        opcode = '0;
        flags = '0;
        stall = 1'b0;
        vecIdx = 0;
        loadVectors();
        if (vecCount == 0) begin
            $display("No vectors could be read from %s", VEC_FILE);
            stopOnFailure();
        end else begin
            @(negedge rst); // One ns after the last reset edge
            for (vecIdx = 0; vecIdx < vecCount; vecIdx++) begin
                if (vecIdx > 0) begin
                    @(posedge clk);
                    #1;
                end
                applyVector(vecIdx * FIELDS);
                #8; // Just before the next edge
                checkVector(vecIdx * FIELDS);
            end
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* project.f */
logic/cpuPkg.sv
logic/decodeBus.sv
logic/instrDecoder.sv
logic/stateSequencer.sv
logic/destDecode.sv
logic/controlGen.sv
logic/cpuController.sv
tb/tbClock.sv
tb/cpuControllerTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --timescale 1ns/1ps -j 0
TOP = cpuControllerTb
FILELIST = project.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/controllerVectors.txt */
// Inputs opcode flags stall then expected state aluFunc aluA aluB memAddr
// Expected bits enA enB enC enSP we re enPC saveOpcode saveMem1 isMul enF sourceF readStack inF
0000 0 0  00 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0  0 // Reset released
0212 0 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0
0212 0 0  02 0 1 2 0  0 1 0 0 0 0 0 0 0 0 1 0 0  0 // A-type add to B
0689 0 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0
0689 0 0  02 4 3 1 0  1 0 0 0 0 0 0 0 0 1 1 0 0  0 // Multiply
0446 0 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0
0446 0 0  02 2 2 0 1  0 0 0 0 1 0 0 0 0 0 1 0 0  0 // Write to (A)
4010 0 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0
4010 0 0  03 0 5 5 0  0 0 0 1 0 0 0 0 0 0 1 0 0  0 // I-type to SP
5605 0 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0
5605 0 0  03 1 3 5 0  0 0 1 0 0 0 0 0 0 0 1 0 0  0
12b3 0 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0
12b3 0 0  05 9 1 5 0  0 0 1 0 0 0 0 0 0 0 1 0 0  0 // SI-type to C
0809 0 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0
0809 0 0  14 0 4 4 0  0 0 0 0 0 1 1 0 1 0 0 0 0  0 // Immediate read
0809 0 0  02 0 6 1 0  1 0 0 0 0 0 0 0 0 0 1 0 0  0
1c21 0 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0
1c21 0 0  15 0 0 0 1  0 0 0 0 0 1 0 0 1 0 0 0 0  0 // Read at (A)
1c21 0 0  05 8 6 5 0  0 1 0 0 0 0 0 0 0 0 1 0 0  0
2608 4 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0
2608 4 0  06 0 4 5 0  0 0 0 0 0 0 1 0 0 0 0 0 0  0 // Taken JFS
2004 1 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0 // JFC not taken
2f00 1 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 1 1 0  9 // FLS flag 3
2900 f 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 1 1 0  d // FLC flag 1
3400 0 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0
3400 0 0  08 0 2 0 2  0 0 0 0 1 0 0 0 0 0 0 0 1  0 // PUSH B
3400 0 0  09 2 5 4 0  0 0 0 1 0 0 0 0 0 0 0 0 0  0
3680 0 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0
3680 0 0  0a 0 5 4 3  0 0 0 1 0 1 0 0 1 0 0 0 1  0 // POP C
3680 0 0  0b 0 6 0 0  0 0 1 0 0 0 0 0 0 0 0 0 0  0
8123 0 1  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0 // Stall in fetch
8123 0 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0
8123 0 1  04 6 4 6 0  0 0 0 0 0 0 1 0 0 0 0 0 0  0 // Stall in jump
8123 0 0  04 6 4 6 0  0 0 0 0 0 0 1 0 0 0 0 0 0  0
0a09 0 0  01 0 4 4 0  0 0 0 0 0 1 1 1 0 0 0 0 0  0 // Absolute source
3300 0 0  3f 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0  0 // Halted
0212 0 0  3f 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0  0
